//--- rtl/organ_pkg.sv
package organ_pkg;

  // ====================================================================
  // Note selection and tone divider
  // ====================================================================

  typedef logic [2:0] note_code_t;

  localparam note_code_t NOTE_DO  = 3'd0;
  localparam note_code_t NOTE_RE  = 3'd1;
  localparam note_code_t NOTE_MI  = 3'd2;
  localparam note_code_t NOTE_FA  = 3'd3;
  localparam note_code_t NOTE_SO  = 3'd4;
  localparam note_code_t NOTE_LA  = 3'd5;
  localparam note_code_t NOTE_SI  = 3'd6;
  localparam note_code_t NOTE_DO2 = 3'd7;

  // Switch inputs of the organ
  typedef struct packed {
    logic       audio_en;
    note_code_t note_sel;
  } organ_ctrl_t;

  typedef logic [31:0] div_count_t;

  // Terminal counts, one tone half-period is count+1 cycles of CLK_50M
  localparam div_count_t NOTE_DIV_COUNT [0:7] = '{
    32'hBAB9, 32'hA65D, 32'h9430, 32'h8BE8,
    32'h7CB8, 32'h6EF9, 32'h62F1, 32'h5D5D
  };

  // ====================================================================
  // Note info text and frequency
  // ====================================================================

  typedef logic [7:0] ascii_t;

  localparam ascii_t CHAR_D     = 8'h44;
  localparam ascii_t CHAR_O     = 8'h4F;
  localparam ascii_t CHAR_R     = 8'h52;
  localparam ascii_t CHAR_E     = 8'h45;
  localparam ascii_t CHAR_M     = 8'h4D;
  localparam ascii_t CHAR_I     = 8'h49;
  localparam ascii_t CHAR_F     = 8'h46;
  localparam ascii_t CHAR_A     = 8'h41;
  localparam ascii_t CHAR_S     = 8'h53;
  localparam ascii_t CHAR_L     = 8'h4C;
  localparam ascii_t CHAR_2     = 8'h32;
  localparam ascii_t CHAR_SPACE = 8'h20;

  // Left character sits in note_text[3]
  typedef struct packed {
    ascii_t [3:0] note_text;
    logic [15:0]  freq_bcd;
  } note_info_t;

  // Audio levels for a low and a high tone
  typedef logic signed [7:0] audio_sample_t;

  localparam audio_sample_t AUDIO_LOW  = 8'h80;
  localparam audio_sample_t AUDIO_HIGH = 8'h7F;

  // ====================================================================
  // Scope speed and seven-segment display
  // ====================================================================

  typedef logic signed [15:0] speed_t;
  typedef logic [15:0]        scope_count_t;

  localparam speed_t       SPEED_STEP            = 16'sd100;
  localparam scope_count_t DEFAULT_SCOPE_COUNT   = 16'd12499;
  localparam int           REPEAT_PERIOD_DEFAULT = 5_000_000;

  localparam int NUM_HEX_DIGITS   = 6;
  localparam int NUM_COUNT_DIGITS = 4;

  // Segments gfedcba, a zero lights the segment
  typedef logic [6:0] seg7_t;
  typedef seg7_t [NUM_HEX_DIGITS-1:0] hex_segs_t;

  localparam seg7_t SEG7_TABLE [0:15] = '{
    7'h40, 7'h79, 7'h24, 7'h30,
    7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03,
    7'h46, 7'h21, 7'h06, 7'h0E
  };

endpackage

//--- rtl/note_table.sv
`timescale 1ns/100ps

module note_table (
  input  organ_pkg::note_code_t note_sel,
  output organ_pkg::div_count_t div_count,
  output organ_pkg::note_info_t info
);

  assign div_count = organ_pkg::NOTE_DIV_COUNT[note_sel];

  // Names are padded on the right with spaces
  always_comb begin
    info.note_text = {4{organ_pkg::CHAR_SPACE}};
    info.freq_bcd  = '0;
    unique case (note_sel)
      organ_pkg::NOTE_DO: begin
        info.note_text[3:2] = {organ_pkg::CHAR_D, organ_pkg::CHAR_O};
        info.freq_bcd       = 16'h0523;
      end
      organ_pkg::NOTE_RE: begin
        info.note_text[3:2] = {organ_pkg::CHAR_R, organ_pkg::CHAR_E};
        info.freq_bcd       = 16'h0587;
      end
      organ_pkg::NOTE_MI: begin
        info.note_text[3:2] = {organ_pkg::CHAR_M, organ_pkg::CHAR_I};
        info.freq_bcd       = 16'h0659;
      end
      organ_pkg::NOTE_FA: begin
        info.note_text[3:2] = {organ_pkg::CHAR_F, organ_pkg::CHAR_A};
        info.freq_bcd       = 16'h0698;
      end
      organ_pkg::NOTE_SO: begin
        info.note_text[3:2] = {organ_pkg::CHAR_S, organ_pkg::CHAR_O};
        info.freq_bcd       = 16'h0783;
      end
      organ_pkg::NOTE_LA: begin
        info.note_text[3:2] = {organ_pkg::CHAR_L, organ_pkg::CHAR_A};
        info.freq_bcd       = 16'h0880;
      end
      organ_pkg::NOTE_SI: begin
        info.note_text[3:2] = {organ_pkg::CHAR_S, organ_pkg::CHAR_I};
        info.freq_bcd       = 16'h0987;
      end
      organ_pkg::NOTE_DO2: begin
        // Upper octave gets a third character
        info.note_text[3:1] = {organ_pkg::CHAR_D, organ_pkg::CHAR_O,
                               organ_pkg::CHAR_2};
        info.freq_bcd       = 16'h1046;
      end
    endcase
  end

endmodule

//--- rtl/tone_generator.sv
`timescale 1ns/100ps

module tone_generator (
  input  logic                     CLK_50M,
  input  logic                     reset,
  input  logic                     audio_en,
  input  organ_pkg::div_count_t    div_count,
  output logic                     tone,
  output organ_pkg::audio_sample_t audio_sample
);

  organ_pkg::div_count_t count;
  organ_pkg::div_count_t div_count_q;

  // Counter runs 0..div_count, tone flips on each wrap
  always_ff @(posedge CLK_50M) begin
    if (reset) begin
      count       <= '0;
      div_count_q <= '0;
      tone        <= 1'b0;
    end else begin
      div_count_q <= div_count;
      if (div_count != div_count_q) begin
        // New note selected, start the half-period over
        count <= '0;
      end else if (count == div_count) begin
        count <= '0;
        tone  <= ~tone;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  // Signed square wave, silent level when disabled
  assign audio_sample = (audio_en && tone) ? organ_pkg::AUDIO_HIGH
                                           : organ_pkg::AUDIO_LOW;

endmodule

//--- rtl/key_repeat.sv
`timescale 1ns/100ps

module key_repeat #(
  parameter int REPEAT_PERIOD = organ_pkg::REPEAT_PERIOD_DEFAULT
) (
  input  logic       CLK_50M,
  input  logic       reset,
  input  logic [2:0] key,
  output logic       up_event,
  output logic       down_event,
  output logic       speed_clear
);

  localparam int CNT_W = $clog2(REPEAT_PERIOD);

  localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(REPEAT_PERIOD - 1);

  logic [2:0]       key_meta;
  logic [2:0]       key_held;
  logic [CNT_W-1:0] repeat_count;
  logic             repeat_tick;

  // Two-stage synchronizer, keys are active low on the board
  always_ff @(posedge CLK_50M) begin
    if (reset) begin
      key_meta <= '0;
      key_held <= '0;
    end else begin
      key_meta <= ~key;
      key_held <= key_meta;
    end
  end

  assign speed_clear = key_held[2];

  // ====================================================================
  // Repeat interval
  // ====================================================================

  assign repeat_tick = (repeat_count == LAST_COUNT);

  always_ff @(posedge CLK_50M) begin
    if (reset) begin
      repeat_count <= '0;
    end else if (repeat_tick) begin
      repeat_count <= '0;
    end else begin
      repeat_count <= repeat_count + 1'b1;
    end
  end

  // One strobe per interval while a direction key is held
  always_ff @(posedge CLK_50M) begin
    if (reset) begin
      up_event   <= 1'b0;
      down_event <= 1'b0;
    end else begin
      up_event   <= repeat_tick && key_held[0];
      down_event <= repeat_tick && key_held[1];
    end
  end

endmodule

//--- rtl/scope_rate_ctrl.sv
`timescale 1ns/100ps

module scope_rate_ctrl (
  input  logic                    CLK_50M,
  input  logic                    reset,
  input  logic                    up_event,
  input  logic                    down_event,
  input  logic                    speed_clear,
  output organ_pkg::scope_count_t scope_count
);

  organ_pkg::speed_t speed;

  // Signed offset, wraps in 16 bits
  always_ff @(posedge CLK_50M) begin
    if (reset) begin
      speed <= '0;
    end else if (speed_clear) begin
      speed <= '0;
    end else if (up_event && !down_event) begin
      speed <= speed + organ_pkg::SPEED_STEP;
    end else if (down_event && !up_event) begin
      speed <= speed - organ_pkg::SPEED_STEP;
    end
  end

  // Sampling count trails the offset by one cycle
  always_ff @(posedge CLK_50M) begin
    if (reset) begin
      scope_count <= organ_pkg::DEFAULT_SCOPE_COUNT;
    end else begin
      scope_count <= organ_pkg::DEFAULT_SCOPE_COUNT
                   + organ_pkg::scope_count_t'(speed);
    end
  end

endmodule

//--- rtl/hex_display.sv
`timescale 1ns/100ps

module hex_display (
  input  organ_pkg::scope_count_t scope_count,
  output organ_pkg::hex_segs_t    hex
);

  // One decoder per digit, digit 0 is the low nibble
  for (genvar i = 0; i < organ_pkg::NUM_HEX_DIGITS; i++) begin : g_digit
    logic [3:0] nibble;

    if (i < organ_pkg::NUM_COUNT_DIGITS) begin : g_count
      assign nibble = scope_count[4*i +: 4];
    end else begin : g_blank
      // Count is only 16 bits wide
      assign nibble = 4'h0;
    end

    assign hex[i] = organ_pkg::SEG7_TABLE[nibble];
  end

endmodule

//--- rtl/organ_top.sv
`timescale 1ns/100ps

module organ_top #(
  parameter int REPEAT_PERIOD = organ_pkg::REPEAT_PERIOD_DEFAULT
) (
  input  logic                     CLK_50M,
  input  logic                     reset,
  input  organ_pkg::organ_ctrl_t   ctrl,
  input  logic [2:0]               key,
  output organ_pkg::audio_sample_t audio_sample,
  output logic                     tone,
  output organ_pkg::note_info_t    info,
  output organ_pkg::hex_segs_t     hex
);

  organ_pkg::div_count_t   div_count;
  organ_pkg::scope_count_t scope_count;
  logic                    up_event;
  logic                    down_event;
  logic                    speed_clear;

  // ====================================================================
  // Note path
  // ====================================================================

  note_table note_table0 (
    .note_sel  (ctrl.note_sel),
    .div_count (div_count),
    .info      (info)
  );

  tone_generator tone_generator0 (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .audio_en     (ctrl.audio_en),
    .div_count    (div_count),
    .tone         (tone),
    .audio_sample (audio_sample)
  );

  // ====================================================================
  // Scope speed keys and display
  // ====================================================================

  key_repeat #(
    .REPEAT_PERIOD (REPEAT_PERIOD)
  ) key_repeat0 (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .key         (key),
    .up_event    (up_event),
    .down_event  (down_event),
    .speed_clear (speed_clear)
  );

  scope_rate_ctrl scope_rate_ctrl0 (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .up_event    (up_event),
    .down_event  (down_event),
    .speed_clear (speed_clear),
    .scope_count (scope_count)
  );

  // Live count, no display hold register
  hex_display hex_display0 (
    .scope_count (scope_count),
    .hex         (hex)
  );

endmodule

//--- tests/organ_tb.sv
`timescale 1ns/100ps

module organ_tb;

  localparam int          PERIOD        = 50;
  localparam int          HALF_LIMIT    = 70000;
  localparam int          STEP_LIMIT    = 2 * PERIOD + 10;
  localparam logic [15:0] DEFAULT_COUNT = 16'h30D3;

  // One row per note: code, divider count, name text, BCD frequency
  typedef struct packed {
    logic [2:0]  note;
    logic [31:0] div;
    logic [31:0] text;
    logic [15:0] freq;
  } note_vec_t;

  logic                     CLK_50M;
  logic                     reset;
  organ_pkg::organ_ctrl_t   ctrl;
  logic [2:0]               key;
  organ_pkg::audio_sample_t audio_sample;
  logic                     tone;
  organ_pkg::note_info_t    info;
  organ_pkg::hex_segs_t     hex;

  note_vec_t   note_vecs [0:7];
  logic [6:0]  seg_ref [0:15];
  logic [15:0] cur_count;
  integer      seed;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;

  organ_top #(.REPEAT_PERIOD(PERIOD)) dut0 (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .ctrl         (ctrl),
    .key          (key),
    .audio_sample (audio_sample),
    .tone         (tone),
    .info         (info),
    .hex          (hex)
  );

  initial begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ====================================================================
  // Reference models and helpers
  // ====================================================================

  function automatic logic [41:0] expected_hex(input logic [15:0] count);
    logic [41:0] segs;
    for (int d = 0; d < 6; d++) begin
      if (d < 4) begin
        segs[7*d +: 7] = seg_ref[count[4*d +: 4]];
      end else begin
        segs[7*d +: 7] = seg_ref[0];
      end
    end
    return segs;
  endfunction

  task automatic report_mismatch(input string sig, input logic [63:0] exp,
                                 input logic [63:0] got);
    $display("Mismatch at %0t: %s expected %0h, got %0h", $time, sig, exp, got);
    test_errors++;
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      $display("PASS  %s", name);
      tests_passed++;
    end else begin
      $display("FAIL  %s (%0d errors)", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  // Counts cycles until the tone flips, checks the audio level on the way
  task automatic measure_half(input int limit, output int cycles);
    logic       start_level;
    logic [7:0] exp_audio;
    start_level = tone;
    cycles = 0;
    while (tone === start_level && cycles < limit) begin
      @(negedge CLK_50M);
      cycles++;
      exp_audio = (ctrl.audio_en && tone) ? 8'h7F : 8'h80;
      assert (audio_sample === exp_audio)
        else report_mismatch("audio_sample", exp_audio, {audio_sample});
    end
    assert (tone !== start_level) else begin
      $display("Timeout at %0t: tone did not toggle within %0d cycles", $time, limit);
      test_errors++;
    end
  endtask

  task automatic wait_hex_change(input logic [15:0] from_count, input int limit,
                                 output bit changed);
    int n;
    changed = 1'b0;
    n = 0;
    while (!changed && n < limit) begin
      @(negedge CLK_50M);
      n++;
      changed = (hex !== expected_hex(from_count));
    end
  endtask

  // Holds a direction key for 1 to 4 intervals, one step per interval
  task automatic press_speed_key(input logic [2:0] key_val, input int delta,
                                 input string name);
    int holds;
    bit changed;
    holds = 1 + ($unsigned($random(seed)) % 4);
    $display("%s key held for %0d intervals", name, holds);
    @(posedge CLK_50M);
    key <= key_val;
    for (int n = 0; n < holds; n++) begin
      wait_hex_change(cur_count, STEP_LIMIT, changed);
      assert (changed) else begin
        $display("Timeout at %0t: hex did not step on %s event %0d", $time, name, n);
        test_errors++;
      end
      if (!changed) begin
        break;
      end
      assert (hex === expected_hex(cur_count + delta))
        else report_mismatch("hex", expected_hex(cur_count + delta), hex);
      cur_count = cur_count + delta;
    end
    @(posedge CLK_50M);
    key <= 3'b111;
    wait_hex_change(cur_count, STEP_LIMIT, changed);
    assert (!changed) else begin
      $display("Error at %0t: hex kept stepping after %s key release", $time, name);
      test_errors++;
    end
  endtask

  task automatic reset_dut();
    @(posedge CLK_50M);
    reset <= 1'b1;
    repeat (5) @(posedge CLK_50M);
    reset <= 1'b0;
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================

  initial begin
    int cycles;
    bit changed;
    reset        = 1'b1;
    ctrl         = '0;
    key          = 3'b111;
    seed         = 32'hfffb_8ea3;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    note_vecs[0] = {3'd0, 32'h0000_BAB9, "DO  ", 16'h0523};
    note_vecs[1] = {3'd1, 32'h0000_A65D, "RE  ", 16'h0587};
    note_vecs[2] = {3'd2, 32'h0000_9430, "MI  ", 16'h0659};
    note_vecs[3] = {3'd3, 32'h0000_8BE8, "FA  ", 16'h0698};
    note_vecs[4] = {3'd4, 32'h0000_7CB8, "SO  ", 16'h0783};
    note_vecs[5] = {3'd5, 32'h0000_6EF9, "LA  ", 16'h0880};
    note_vecs[6] = {3'd6, 32'h0000_62F1, "SI  ", 16'h0987};
    note_vecs[7] = {3'd7, 32'h0000_5D5D, "DO2 ", 16'h1046};
    seg_ref = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
    repeat (5) @(posedge CLK_50M);
    reset <= 1'b0;

    for (int i = 0; i < 8; i++) begin
      @(posedge CLK_50M);
      ctrl.audio_en <= 1'b1;
      ctrl.note_sel <= note_vecs[i].note;
      @(negedge CLK_50M);
      assert (info.note_text === note_vecs[i].text)
        else report_mismatch("info.note_text", note_vecs[i].text, info.note_text);
      assert (info.freq_bcd === note_vecs[i].freq)
        else report_mismatch("info.freq_bcd", note_vecs[i].freq, info.freq_bcd);
      // First edge ends a partial half-period
      measure_half(HALF_LIMIT, cycles);
      for (int h = 0; h < 2; h++) begin
        measure_half(HALF_LIMIT, cycles);
        assert (cycles == note_vecs[i].div + 1)
          else report_mismatch("tone half-period", note_vecs[i].div + 1, cycles);
      end
      end_test($sformatf("note %0d tone, audio and info", i));
    end

    @(posedge CLK_50M);
    ctrl.audio_en <= 1'b0;
    // Long mute check runs inside a high tone half
    measure_half(HALF_LIMIT, cycles);
    if (tone !== 1'b1) begin
      measure_half(HALF_LIMIT, cycles);
    end
    for (int n = 0; n < 2000; n++) begin
      @(negedge CLK_50M);
      assert (audio_sample === 8'h80)
        else report_mismatch("audio_sample", 8'h80, {audio_sample});
    end
    measure_half(HALF_LIMIT, cycles);
    measure_half(HALF_LIMIT, cycles);
    assert (cycles == note_vecs[7].div + 1)
      else report_mismatch("tone half-period", note_vecs[7].div + 1, cycles);
    end_test("audio muted, tone running");

    reset_dut();
    @(negedge CLK_50M);
    cur_count = DEFAULT_COUNT;
    assert (hex === expected_hex(DEFAULT_COUNT))
      else report_mismatch("hex", expected_hex(DEFAULT_COUNT), hex);
    end_test("hex after reset");

    press_speed_key(3'b110, 100, "up");
    end_test("up key steps");
    press_speed_key(3'b101, -100, "down");
    end_test("down key steps");

    // Count has to sit off the default for the clear to show
    if (cur_count == DEFAULT_COUNT) begin
      press_speed_key(3'b110, 100, "up");
    end
    @(posedge CLK_50M);
    key <= 3'b011;
    changed = 1'b0;
    for (int n = 0; n < 20 && !changed; n++) begin
      @(negedge CLK_50M);
      changed = (hex === expected_hex(DEFAULT_COUNT));
    end
    assert (changed) else begin
      $display("Timeout at %0t: hex did not return to the default count", $time);
      test_errors++;
    end
    @(posedge CLK_50M);
    key <= 3'b111;
    end_test("speed reset key");

    $display("%0d tests run, %0d passed, %0d failed",
             tests_passed + tests_failed, tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
rtl/organ_pkg.sv
rtl/note_table.sv
rtl/tone_generator.sv
rtl/key_repeat.sv
rtl/scope_rate_ctrl.sv
rtl/hex_display.sv
rtl/organ_top.sv
tests/organ_tb.sv
